/* hw/obj_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object table geometry and record types, shared by
// the line scanner, its helpers and the renderer stub
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package obj_pkg;

    localparam int obj_entries = 256;                // objects per frame table
    localparam int obj_words   = 4;                  // x, y, code, attr
    localparam int tile_px     = 16;                 // tile side, also renderer busy time

    localparam int ent_w    = $clog2(obj_entries);
    localparam int word_w   = $clog2(obj_words);
    localparam int frame_aw = ent_w + word_w;        // table word address

    // word order inside one entry
    localparam logic [word_w-1:0] w_x    = 0;
    localparam logic [word_w-1:0] w_y    = 1;
    localparam logic [word_w-1:0] w_code = 2;
    localparam logic [word_w-1:0] w_attr = 3;

    // attr fields, lsb of each 4-bit count field
    localparam int tile_m = 12;                      // extra rows, bits 15..12
    localparam int tile_n = 8;                       // extra columns, bits 11..8
    localparam int vflip  = 6;
    localparam int hflip  = 5;

    typedef struct packed {
        logic [8:0]  x;
        logic [9:0]  y;
        logic [15:0] code;
        logic [15:0] attr;
    } obj_entry_t;

    // one tile handed to the renderer
    typedef struct packed {
        logic [15:0] code;                           // mapped code plus row/column
        logic [15:0] attr;                           // {0, vsub, attr[7:0]}
        logic [8:0]  hpos;
    } obj_tile_t;

endpackage

`default_nettype wire

/* hw/obj_frame_ram.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object frame table, cpu write side and scan read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_frame_ram (
    input  wire                          clk,
    input  wire                          cpu_we,
    input  wire [obj_pkg::frame_aw-1:0]  cpu_addr,
    input  wire [15:0]                   cpu_data,
    input  wire [obj_pkg::frame_aw-1:0]  scan_addr,
    output logic [15:0]                  frame_data
);
    import obj_pkg::*;

    logic [15:0] mem [0:obj_entries*obj_words-1];    // 4 words per object

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_data;
        end
        frame_data <= mem[scan_addr];                 // one cycle read latency
    end

endmodule

`default_nettype wire

/* hw/gfx_bank_mapper.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile code bank translation, one offset/mask rule
// in place of the per-game mapper tables
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module gfx_bank_mapper (
    input  wire        clk,
    input  wire        rst,
    input  wire  [3:0] bank_in,                      // top nibble of the tile code
    input  wire  [3:0] bank_offset,
    input  wire  [3:0] bank_mask,
    output logic [3:0] bank_out,
    output logic       unmapped
);

    logic [3:0] outside;

    // bank bits the mask does not allow
    assign outside = bank_in & ~bank_mask;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_out <= 4'd0;
            unmapped <= 1'b0;
        end else begin
            bank_out <= (bank_in & bank_mask) | bank_offset;
            unmapped <= |outside;                    // code not in this bank
        end
    end

endmodule

`default_nettype wire

/* hw/obj_tile_match.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vertical zone check and tile row/column selection
// for the entry the scanner currently holds
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_tile_match (
    input  wire obj_pkg::obj_entry_t entry,
    input  wire [8:0]                vline,          // line after screen flip
    input  wire [3:0]                n,              // column index
    output logic                     inzone,
    output logic [3:0]               vsub,
    output logic [15:0]              code_mn
);
    import obj_pkg::*;

    logic [9:0] dy;
    logic [9:0] zone_h;
    logic [3:0] ext_m;
    logic [3:0] row;
    logic [3:0] row_f;
    logic       v_flip;

    assign ext_m  = entry.attr[tile_m +: 4];
    assign v_flip = entry.attr[vflip];

    // distance from object top, wraps at 1024
    assign dy     = {1'b0, vline} - entry.y;
    assign zone_h = ({6'd0, ext_m} + 10'd1) * 10'(tile_px);
    assign inzone = dy < zone_h;

    assign row   = dy[7:4];                          // dy / 16, only valid in zone
    assign row_f = v_flip ? ext_m - row : row;
    assign vsub  = v_flip ? ~dy[3:0] : dy[3:0];

    // row and column go in per nibble, no carry between them
    assign code_mn = {entry.code[15:8],
                      entry.code[7:4] + row_f,
                      entry.code[3:0] + n};

endmodule

`default_nettype wire

/* hw/obj_line_scan.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// walks the frame table one line ahead, filters the
// objects and issues one draw strobe per tile
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_line_scan (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flip,
    input  wire [8:0]                    vrender,        // one line ahead of display
    input  wire                          start,
    // frame table
    output logic [obj_pkg::frame_aw-1:0] scan_addr,
    input  wire [15:0]                   frame_data,
    // bank mapper
    output logic [3:0]                   bank_in,
    input  wire [3:0]                    bank_out,
    input  wire                          unmapped,
    // tile matcher
    output obj_pkg::obj_entry_t          cur_entry,
    output logic [8:0]                   vline,
    output logic [3:0]                   n,
    input  wire                          inzone,
    input  wire [3:0]                    vsub,
    input  wire [15:0]                   code_mn,
    // renderer
    output logic                         dr_start,
    output obj_pkg::obj_tile_t           dr_tile,
    input  wire                          dr_idle,
    output logic                         line_done
);
    import obj_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_rd_x,
        st_rd_y,
        st_rd_code,
        st_rd_attr,
        st_map,
        st_vis,
        st_draw,
        st_rel,
        st_next
    } scan_st_t;

    scan_st_t   st;
    obj_entry_t raw;                                 // words as read with code unmapped
    obj_entry_t prev;                                // previous entry for the repeat filter
    logic [ent_w-1:0] ent;                           // counts 255 down to 0
    logic [3:0] npos;                                // x position of the column
    logic [3:0] ext_n;
    logic       first;                               // no tile yet this line
    logic       repeated;
    logic       reject;
    logic       ent_end;

    assign ext_n    = raw.attr[tile_n +: 4];
    assign repeated = raw == prev;
    assign reject   = unmapped || !inzone || (repeated && !first);

    // last step of an entry when dropped or after its final column
    assign ent_end = (st == st_vis && reject) || (st == st_next && n == ext_n);

    assign bank_in   = raw.code[15:12];              // mapper answers in st_vis
    assign cur_entry = '{x: raw.x, y: raw.y, code: {bank_out, raw.code[11:0]}, attr: raw.attr};

    // word picked by state with data back in the next state
    always_comb begin
        case (st)
            st_rd_y:    scan_addr = {ent, w_y};
            st_rd_code: scan_addr = {ent, w_code};
            st_rd_attr: scan_addr = {ent, w_attr};
            default:    scan_addr = {ent, w_x};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= st_idle;
            ent       <= '0;
            first     <= 1'b1;
            n         <= 4'd0;
            npos      <= 4'd0;
            dr_start  <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (st)
                st_idle: begin
                    if (start) begin                 // ignored while busy
                        ent   <= '1;
                        first <= 1'b1;
                        st    <= st_rd_x;
                    end
                end
                st_rd_x:    st <= st_rd_y;
                st_rd_y:    st <= st_rd_code;
                st_rd_code: st <= st_rd_attr;
                st_rd_attr: st <= st_map;
                st_map:     st <= st_vis;            // mapper result lands here
                st_vis: begin
                    if (!reject) begin
                        first <= 1'b0;
                        n     <= 4'd0;
                        npos  <= raw.attr[hflip] ? ext_n : 4'd0; // hflip starts at the right
                        st    <= st_draw;
                    end
                end
                st_draw: begin
                    if (dr_idle) begin               // hold while renderer busy
                        dr_start <= 1'b1;
                        st       <= st_rel;
                    end
                end
                st_rel: begin
                    dr_start <= 1'b0;
                    st       <= st_next;
                end
                st_next: begin
                    if (n != ext_n) begin
                        n    <= n + 4'd1;
                        npos <= raw.attr[hflip] ? npos - 4'd1 : npos + 4'd1;
                        st   <= st_draw;
                    end
                end
                default: st <= st_idle;
            endcase

            if (ent_end) begin
                if (ent == '0) begin
                    st        <= st_idle;            // whole table done
                    line_done <= 1'b1;
                end else begin
                    ent <= ent - ent_w'(1);
                    st  <= st_rd_x;
                end
            end
        end
    end

    // entry words, line and draw record
    always_ff @(posedge clk) begin
        if (st == st_idle && start) begin
            vline <= vrender ^ {1'b0, {8{flip}}};
        end
        case (st)
            st_rd_y: begin
                prev  <= raw;                        // kept even for skipped entries
                raw.x <= frame_data[8:0];
            end
            st_rd_code: raw.y    <= frame_data[9:0];
            st_rd_attr: raw.code <= frame_data;
            st_map:     raw.attr <= frame_data;
            st_draw: begin
                if (dr_idle) begin
                    dr_tile.code <= code_mn;
                    dr_tile.attr <= {4'd0, vsub, raw.attr[7:0]};
                    dr_tile.hpos <= raw.x + {1'b0, npos, 4'd0} - 9'd1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/obj_draw_timer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// renderer stand-in, takes a tile and stays busy
// for one tile width of pixel clocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_draw_timer (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      dr_start,
    input  wire obj_pkg::obj_tile_t  dr_tile,
    output logic                     dr_idle,
    output logic                     draw_valid,
    output obj_pkg::obj_tile_t       draw_tile,
    output logic                     draw_busy
);
    import obj_pkg::*;

    logic [4:0] px_cnt;                              // pixels left to draw

    assign draw_busy = px_cnt != 5'd0;
    assign dr_idle   = !draw_valid && !draw_busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_valid <= 1'b0;
            px_cnt     <= 5'd0;
        end else begin
            draw_valid <= dr_start;                  // one cycle after the strobe
            if (draw_valid) begin
                px_cnt <= 5'(tile_px);               // busy starts after the valid pulse
            end else if (draw_busy) begin
                px_cnt <= px_cnt - 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start) begin
            draw_tile <= dr_tile;
        end
    end

endmodule

`default_nettype wire

/* hw/obj_line_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite line scanner top, table ram, scanner,
// mapper, tile matcher and renderer stub
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module obj_line_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          cpu_we,
    input  wire [obj_pkg::frame_aw-1:0]  cpu_addr,
    input  wire [15:0]                   cpu_data,
    input  wire                          flip,
    input  wire [8:0]                    vrender,
    input  wire                          start,
    input  wire [3:0]                    bank_offset,
    input  wire [3:0]                    bank_mask,
    output logic                         draw_valid,
    output obj_pkg::obj_tile_t           draw_tile,
    output logic                         draw_busy,
    output logic                         line_done
);
    import obj_pkg::*;

    logic [frame_aw-1:0] scan_addr;
    logic [15:0]         frame_data;
    logic [3:0]          bank_in;
    logic [3:0]          bank_out;
    logic                unmapped;
    obj_entry_t          cur_entry;                  // scanner entry for the matcher
    logic [8:0]          vline;
    logic [3:0]          n;
    logic                inzone;
    logic [3:0]          vsub;
    logic [15:0]         code_mn;
    logic                dr_start;
    obj_tile_t           dr_tile;
    logic                dr_idle;

    obj_frame_ram i_obj_frame_ram (
        .clk, .cpu_we, .cpu_addr, .cpu_data, .scan_addr, .frame_data
    );

    gfx_bank_mapper i_gfx_bank_mapper (
        .clk, .rst, .bank_in, .bank_offset, .bank_mask, .bank_out, .unmapped
    );

    obj_tile_match i_obj_tile_match (
        .entry(cur_entry), .vline, .n, .inzone, .vsub, .code_mn
    );

    obj_line_scan i_obj_line_scan (
        .clk, .rst, .flip, .vrender, .start, .scan_addr, .frame_data,
        .bank_in, .bank_out, .unmapped, .cur_entry, .vline, .n,
        .inzone, .vsub, .code_mn, .dr_start, .dr_tile, .dr_idle, .line_done
    );

    obj_draw_timer i_obj_draw_timer (
        .clk, .rst, .dr_start, .dr_tile, .dr_idle, .draw_valid, .draw_tile, .draw_busy
    );

endmodule

`default_nettype wire

/* bench/tb_obj_line.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sprite line scanner that runs a
// table of lines and checks each draw record on a model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_obj_line;
    import obj_pkg::*;

    typedef struct packed {
        logic [95:0] name;                           // 12 chars
        logic [8:0]  vrender;
        logic        flip;
        logic [3:0]  offset;
        logic [3:0]  mask;
        logic [1:0]  set;                            // directed object set
        logic        rnd;                            // random table fill
        logic [9:0]  tiles;                          // expected tile count of a directed row
    } row_t;

    localparam int n_rows = 11;
    localparam int period = 40;

    logic                clk = 1'b0;
    logic                rst;
    logic                cpu_we;
    logic [frame_aw-1:0] cpu_addr;
    logic [15:0]         cpu_data;
    logic                flip;
    logic [8:0]          vrender;
    logic                start;
    logic [3:0]          bank_offset;
    logic [3:0]          bank_mask;
    logic                draw_valid;
    obj_tile_t           draw_tile;
    logic                draw_busy;
    logic                line_done;

    row_t        rows [n_rows];
    obj_entry_t  tbl [obj_entries];                  // copy of what the cpu wrote
    obj_tile_t   exp_q [$];
    logic [31:0] lfsr = 32'hadd;
    logic [95:0] cur_name;
    time         deadline = 64'd80000;
    int          busy_left;
    logic        done_seen;

    obj_line_top i_obj_line_top (
        .clk, .rst, .cpu_we, .cpu_addr, .cpu_data, .flip, .vrender, .start,
        .bank_offset, .bank_mask, .draw_valid, .draw_tile, .draw_busy, .line_done
    );

    always #(period/2) clk = ~clk;

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_tile(input string what, input obj_tile_t exp_v, input obj_tile_t act_v);
        if (act_v !== exp_v) begin
            // code/attr/hpos
            $display("Mismatch %0s %0s: expected %h/%h/%h, actual %h/%h/%h", cur_name, what,
                     exp_v.code, exp_v.attr, exp_v.hpos, act_v.code, act_v.attr, act_v.hpos);
            stop_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %0s %0s: expected %b, actual %b", cur_name, what, exp_v, act_v);
            stop_run();
        end
    endtask

    task automatic check_count(input string what, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            $display("Mismatch %0s %0s: expected %0d, actual %0d", cur_name, what, exp_v, act_v);
            stop_run();
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(input int nb);
        logic [15:0] v;
        v = 16'd0;
        for (int i = 0; i < nb; i++) begin
            lfsr = lfsr_next(lfsr);                  // one step per bit
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic write_word(input logic [frame_aw-1:0] a, input logic [15:0] d);
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_data = d;
        @(negedge clk);
    endtask

    task automatic write_entry(input int idx, input obj_entry_t e);
        logic [ent_w-1:0] ei;
        ei       = idx[ent_w-1:0];
        tbl[idx] = e;
        write_word({ei, w_x}, {7'd0, e.x});
        write_word({ei, w_y}, {6'd0, e.y});
        write_word({ei, w_code}, e.code);
        write_word({ei, w_attr}, e.attr);
    endtask

    task automatic load_table(input row_t r);
        obj_entry_t e;
        for (int i = obj_entries - 1; i >= 0; i--) begin
            if (r.rnd) begin
                e.x    = 9'(rand_bits(9));
                e.y    = 10'(rand_bits(10));
                e.code = rand_bits(16);
                e.attr = rand_bits(16);
            end else begin
                e = '{x: 9'd0, y: 10'd600, code: 16'd0, attr: 16'd0}; // off every line
            end
            write_entry(i, e);
        end
        if (!r.rnd) begin
            case (r.set)
                2'd0: begin
                    e = '{x: 9'd40, y: 10'd100, code: 16'h3125, attr: 16'h0311};
                    write_entry(200, e);
                    e = '{x: 9'd8, y: 10'd100, code: 16'hc0f0, attr: 16'h0000}; // bank c
                    write_entry(150, e);
                    e = '{x: 9'd300, y: 10'd96, code: 16'h2a9e, attr: 16'h1320}; // hflip
                    write_entry(149, e);
                end
                2'd1: begin
                    e = '{x: 9'd64, y: 10'd50, code: 16'h05f0, attr: 16'h2103}; // 3 rows
                    write_entry(100, e);
                    e = '{x: 9'd200, y: 10'd50, code: 16'h0520, attr: 16'h2140}; // vflip
                    write_entry(99, e);
                end
                default: begin
                    e = '{x: 9'd20, y: 10'd25, code: 16'h1200, attr: 16'h0100};
                    write_entry(10, e);
                    write_entry(9, e);                // back to back repeat
                    write_entry(5, e);                // not adjacent so drawn again
                end
            endcase
        end
        cpu_we = 1'b0;
    endtask

    // object rules applied in scan order
    function automatic void build_expected(input row_t r);
        obj_entry_t prev;
        obj_entry_t e;
        obj_tile_t  t;
        logic       first;
        logic [8:0] vl;
        logic [9:0] dy;
        logic [3:0] c, bank, m, nn, row, vs, npos;
        exp_q.delete();
        prev  = '0;
        first = 1'b1;
        vl    = r.flip ? r.vrender ^ 9'h0ff : r.vrender;
        for (int i = obj_entries - 1; i >= 0; i--) begin
            e  = tbl[i];
            c  = e.code[15:12];
            m  = e.attr[15:12];
            nn = e.attr[11:8];
            dy = {1'b0, vl} - e.y;                   // wraps at 1024
            if ((c & ~r.mask) == 4'd0 && int'(dy) < tile_px * (int'(m) + 1)
                    && !(!first && e == prev)) begin
                first = 1'b0;
                bank  = (c & r.mask) | r.offset;
                row   = dy[7:4];
                vs    = dy[3:0];
                if (e.attr[vflip]) begin
                    row = m - row;
                    vs  = 4'd15 - vs;
                end
                for (int k = 0; k <= int'(nn); k++) begin
                    npos   = e.attr[hflip] ? nn - 4'(k) : 4'(k);
                    t.code = {bank, e.code[11:8], e.code[7:4] + row, e.code[3:0] + 4'(k)};
                    t.attr = {4'd0, vs, e.attr[7:0]};
                    t.hpos = e.x + 9'(tile_px) * {5'd0, npos} - 9'd1;
                    exp_q.push_back(t);
                end
            end
            prev = e;                                // skipped entries count too
        end
    endfunction

    // draw records, busy length and line end
    always @(negedge clk) begin
        if (!rst) begin
            if (draw_valid) begin
                check_bit("draw_busy at valid", 1'b0, draw_busy);
                if (exp_q.size() == 0) begin
                    $display("%0s: extra draw record %h with nothing left to expect",
                             cur_name, draw_tile);
                    stop_run();
                end else begin
                    check_tile("draw_tile", exp_q.pop_front(), draw_tile);
                    busy_left = tile_px;
                end
            end else if (busy_left > 0) begin
                check_bit("draw_busy", 1'b1, draw_busy);
                busy_left--;
            end else begin
                check_bit("draw_busy idle", 1'b0, draw_busy);
            end
            if (line_done) begin
                check_bit("line_done once", 1'b0, done_seen);
                check_bit("queue empty at line_done", 1'b1, exp_q.size() == 0);
                done_seen = 1'b1;
            end
        end
    end

    // deadline moves with each line's expected length
    always @(posedge clk) begin
        if ($time > deadline) begin
            $display("watchdog: %0s did not finish before its deadline", cur_name);
            stop_run();
        end
    end

    initial begin
        rst         = 1'b1;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_data    = 16'd0;
        flip        = 1'b0;
        vrender     = 9'd0;
        start       = 1'b0;
        bank_offset = 4'd0;
        bank_mask   = 4'hf;
        cur_name    = "reset       ";
        done_seen   = 1'b0;
        busy_left   = 0;
        //          name             vrender  flip  offset mask  set   rnd   tiles
        rows[0]  = '{"bank_masked ", 9'd100, 1'b0, 4'h4, 4'h3, 2'd0, 1'b0, 10'd8};
        rows[1]  = '{"bank_open   ", 9'd100, 1'b0, 4'h0, 4'hf, 2'd0, 1'b0, 10'd9};
        rows[2]  = '{"zone_top    ", 9'd50,  1'b0, 4'h0, 4'hf, 2'd1, 1'b0, 10'd4};
        rows[3]  = '{"zone_bottom ", 9'd97,  1'b0, 4'h0, 4'hf, 2'd1, 1'b0, 10'd4};
        rows[4]  = '{"zone_above  ", 9'd49,  1'b0, 4'h0, 4'hf, 2'd1, 1'b0, 10'd0};
        rows[5]  = '{"zone_below  ", 9'd98,  1'b0, 4'h0, 4'hf, 2'd1, 1'b0, 10'd0};
        rows[6]  = '{"screen_flip ", 9'd195, 1'b1, 4'h0, 4'hf, 2'd1, 1'b0, 10'd4}; // line 60
        rows[7]  = '{"repeat_skip ", 9'd30,  1'b0, 4'h0, 4'hf, 2'd2, 1'b0, 10'd4};
        rows[8]  = '{"random_a    ", 9'd17,  1'b0, 4'h2, 4'he, 2'd0, 1'b1, 10'd0};
        rows[9]  = '{"random_b    ", 9'd300, 1'b1, 4'h0, 4'hf, 2'd0, 1'b1, 10'd0};
        rows[10] = '{"random_c    ", 9'd480, 1'b0, 4'h8, 4'h7, 2'd0, 1'b1, 10'd0};
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_bit("draw_valid after reset", 1'b0, draw_valid);
        check_bit("draw_busy after reset", 1'b0, draw_busy);
        check_bit("line_done after reset", 1'b0, line_done);
        for (int i = 0; i < n_rows; i++) begin
            cur_name    = rows[i].name;
            deadline    = $time + 64'(1200 * period);  // table load
            vrender     = rows[i].vrender;
            flip        = rows[i].flip;
            bank_offset = rows[i].offset;
            bank_mask   = rows[i].mask;
            load_table(rows[i]);
            build_expected(rows[i]);
            if (!rows[i].rnd) begin
                check_count("model tiles", int'(rows[i].tiles), exp_q.size());
            end
            deadline  = $time + 64'((obj_entries * 6 + 19 * exp_q.size() + 100) * period);
            done_seen = 1'b0;
            start     = 1'b1;
            @(negedge clk);
            start = 1'b0;
            if (rows[i].rnd) begin
                // a restart after the first record would replay it
                while (!draw_valid && !line_done) @(negedge clk);
                if (!line_done) begin
                    start = 1'b1;                    // mid-scan pulse is ignored
                    @(negedge clk);
                    start = 1'b0;
                end
            end
            while (!line_done) @(negedge clk);
            repeat (40) @(negedge clk);              // quiet gap after line end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/obj_pkg.sv
hw/obj_frame_ram.sv
hw/gfx_bank_mapper.sv
hw/obj_tile_match.sv
hw/obj_line_scan.sv
hw/obj_draw_timer.sv
hw/obj_line_top.sv
bench/tb_obj_line.sv

/* run_sim.sh */
#!/bin/sh
# builds the sprite line scanner testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_obj_line -f tb.f -o tb_obj_line_sim

./obj_dir/tb_obj_line_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
